//--- rtl/axis_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module axis_fifo
    import stream_cfg_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic           clk_i,
    input  wire logic           m_reset_ni,

    input  wire payload_t       wr_data_i,
    input  wire logic           wr_valid_i,
    output logic                full_o,

    output payload_t            rd_data_o,
    output logic                rd_valid_o,
    input  wire logic           rd_ready_i,
    output logic [PTR_WIDTH:0]  level_o,
    output logic                empty_o
);

    payload_t               mem [FIFO_LEN];

    // Pointers carry one extra bit so that a full memory differs from an empty one
    logic [PTR_WIDTH:0]     wr_ptr;
    logic [PTR_WIDTH:0]     rd_ptr;
    logic [PTR_WIDTH-1:0]   wr_addr;
    logic [PTR_WIDTH-1:0]   rd_addr;

    logic                   mem_empty;
    logic                   wr_en;
    logic                   rd_load;

    assign wr_addr   = wr_ptr[PTR_WIDTH-1:0];
    assign rd_addr   = rd_ptr[PTR_WIDTH-1:0];
    assign mem_empty = (wr_ptr == rd_ptr);

    // The input side has no ready, so a write while full is simply lost
    assign wr_en = wr_valid_i && !full_o;

    // Read ahead whenever the output register is free or is being drained
    assign rd_load = !mem_empty && (!rd_valid_o || rd_ready_i);

    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            rd_ptr     <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            // Valid stays up while data waits in memory or the held word is not taken
            rd_valid_o <= !mem_empty || (rd_valid_o && !rd_ready_i);
            if (rd_load) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_load) begin
            rd_data_o <= mem[rd_addr];
        end
    end

    // Level counts the words in memory plus the one waiting in the output register
    assign level_o = (wr_ptr - rd_ptr) + {{PTR_WIDTH{1'b0}}, rd_valid_o};
    assign empty_o = mem_empty && !rd_valid_o;

    // Full one entry early, as the write side cannot be stalled
    assign full_o = (level_o == (PTR_WIDTH + 1)'(FIFO_LEN - 1));

endmodule

`default_nettype wire

//--- rtl/decim_accum.sv
`default_nettype none
`timescale 1ns/100ps

module decim_accum
    import stream_cfg_pkg::*;
    import stream_fmt_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       m_reset_ni,

    input  wire sample_t    sample_i,
    input  wire logic       acc_en_i,
    input  wire logic       acc_last_i,

    output logic            push_o,
    output result_t         result_o
);

    logic signed [SUM_WIDTH-1:0]    sum_q;
    logic signed [SUM_WIDTH-1:0]    sample_ext;
    logic signed [SUM_WIDTH-1:0]    sum_next;
    logic                           close_win;

    assign sample_ext = {{(SUM_WIDTH - SAMPLE_WIDTH){sample_i.data[SAMPLE_WIDTH-1]}},
                         sample_i.data};
    assign sum_next   = sum_q + sample_ext;
    assign close_win  = acc_en_i && acc_last_i;

    // Running sum of the open window, cleared when the window closes
    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            sum_q  <= '0;
            push_o <= 1'b0;
        end else begin
            push_o <= close_win;
            if (close_win) begin
                sum_q <= '0;
            end else if (acc_en_i) begin
                sum_q <= sum_next;
            end
        end
    end

    // The closing sample is part of the sum and gives the result its tag and last flag
    always_ff @(posedge clk_i) begin
        if (close_win) begin
            result_o.sum  <= sum_next;
            result_o.user <= sample_i.user;
            result_o.last <= sample_i.last;
        end
    end

endmodule

`default_nettype wire

//--- rtl/decim_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module decim_ctrl
    import stream_cfg_pkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               m_reset_ni,

    input  wire logic               in_valid_i,
    input  wire logic               in_full_i,

    input  wire logic               fifo_valid_i,
    input  wire logic               sample_last_i,
    input  wire logic               out_full_i,
    input  wire logic               push_pending_i,

    output logic                    pop_o,
    output logic                    acc_en_o,
    output logic                    acc_last_o,
    output logic [CNT_WIDTH-1:0]    drop_count_o
);

    logic [WIN_WIDTH-1:0]   win_cnt;
    logic                   win_full;
    logic                   out_blocked;

    // A push lands one cycle after the closing pop. Popping waits while the
    // output FIFO is full or a push is still on its way, so every push finds room
    assign out_blocked = out_full_i || push_pending_i;
    assign pop_o       = fifo_valid_i && !out_blocked;

    assign win_full   = (win_cnt == WIN_WIDTH'(DECIM - 1));
    assign acc_en_o   = pop_o;
    assign acc_last_o = pop_o && (win_full || sample_last_i);

    // Window counter, restarts after each closing pop
    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            win_cnt <= '0;
        end else if (acc_last_o) begin
            win_cnt <= '0;
        end else if (pop_o) begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    // Strobes that arrive while the input FIFO reports full are lost, count them
    always_ff @(posedge clk_i) begin
        if (!m_reset_ni) begin
            drop_count_o <= '0;
        end else if (in_valid_i && in_full_i && (drop_count_o != '1)) begin
            drop_count_o <= drop_count_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/decim_stream_top.sv
`default_nettype none
`timescale 1ns/100ps

module decim_stream_top
    import stream_cfg_pkg::*;
    import stream_fmt_pkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               m_reset_ni,

    input  wire sample_t            in_sample_i,
    input  wire logic               in_valid_i,
    output logic                    in_full_o,

    output result_t                 out_result_o,
    output logic                    out_valid_o,
    input  wire logic               out_ready_i,

    output logic [CNT_WIDTH-1:0]    drop_count_o
);

    sample_t    fifo_sample;
    logic       fifo_valid;
    logic       pop;
    logic       acc_en;
    logic       acc_last;
    logic       push;
    result_t    acc_result;
    logic       out_full;

    // Input samples, the write side is a plain strobe
    axis_fifo #(
        .payload_t  (sample_t)
    ) in_fifo_i (
        .clk_i      (clk_i),
        .m_reset_ni (m_reset_ni),
        .wr_data_i  (in_sample_i),
        .wr_valid_i (in_valid_i),
        .full_o     (in_full_o),
        .rd_data_o  (fifo_sample),
        .rd_valid_o (fifo_valid),
        .rd_ready_i (pop),
        .level_o    (),
        .empty_o    ()
    );

    decim_ctrl ctrl_i (
        .clk_i          (clk_i),
        .m_reset_ni     (m_reset_ni),
        .in_valid_i     (in_valid_i),
        .in_full_i      (in_full_o),
        .fifo_valid_i   (fifo_valid),
        .sample_last_i  (fifo_sample.last),
        .out_full_i     (out_full),
        .push_pending_i (push),
        .pop_o          (pop),
        .acc_en_o       (acc_en),
        .acc_last_o     (acc_last),
        .drop_count_o   (drop_count_o)
    );

    decim_accum accum_i (
        .clk_i      (clk_i),
        .m_reset_ni (m_reset_ni),
        .sample_i   (fifo_sample),
        .acc_en_i   (acc_en),
        .acc_last_i (acc_last),
        .push_o     (push),
        .result_o   (acc_result)
    );

    // Finished sums, drained through the valid/ready port
    axis_fifo #(
        .payload_t  (result_t)
    ) out_fifo_i (
        .clk_i      (clk_i),
        .m_reset_ni (m_reset_ni),
        .wr_data_i  (acc_result),
        .wr_valid_i (push),
        .full_o     (out_full),
        .rd_data_o  (out_result_o),
        .rd_valid_o (out_valid_o),
        .rd_ready_i (out_ready_i),
        .level_o    (),
        .empty_o    ()
    );

endmodule

`default_nettype wire

//--- rtl/stream_cfg_pkg.sv
`default_nettype none

package stream_cfg_pkg;

    // Width of one input sample in bits
    localparam int SAMPLE_WIDTH = 16;

    // Samples per full decimation window
    localparam int DECIM = 4;
    localparam int WIN_WIDTH = $clog2(DECIM);

    // A sum of DECIM signed samples needs log2(DECIM) extra bits to stay exact
    localparam int SUM_WIDTH = SAMPLE_WIDTH + $clog2(DECIM);

    // Depth of each FIFO, must be a power of two
    localparam int FIFO_LEN = 8;
    localparam int PTR_WIDTH = $clog2(FIFO_LEN);

    // The drop counter saturates at its maximum value
    localparam int CNT_WIDTH = 16;

endpackage

`default_nettype wire

//--- rtl/stream_fmt_pkg.sv
`default_nettype none

package stream_fmt_pkg;

    import stream_cfg_pkg::*;

    // One input sample with its user tag and frame-end flag
    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] data;
        logic                           user;
        logic                           last;
    } sample_t;

    // One decimated result, tag and last flag come from the closing sample
    typedef struct packed {
        logic signed [SUM_WIDTH-1:0]    sum;
        logic                           user;
        logic                           last;
    } result_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message in its output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f verilog.f \
    --top-module tb_decim_stream -o tb_decim_stream \
    && sim_out="$(./obj_dir/tb_decim_stream)" \
    || { echo "Build or simulation did not complete"; exit 1; }
echo "$sim_out"
echo "$sim_out" | grep -qx "ALL CHECKS PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- test/tb_clock.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clock #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic m_reset_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Reset is released on a falling edge, away from the edge the DUT samples on
    initial begin
        m_reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        m_reset_no = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_decim_stream.sv
`default_nettype none
`timescale 1ns/100ps

module tb_decim_stream
    import stream_cfg_pkg::*;
    import stream_fmt_pkg::*;
();

    localparam int DRAIN_TIMEOUT = 400;

    logic                   clk;
    logic                   m_reset_n;
    sample_t                in_sample;
    logic                   in_valid;
    logic                   in_full;
    result_t                out_result;
    logic                   out_valid;
    logic                   out_ready;
    logic [CNT_WIDTH-1:0]   drop_count;

    integer     seed;
    result_t    exp_q[$];
    result_t    last_result;
    int         model_sum;
    int         model_cnt;
    int         drop_expected;
    int         result_count;
    int         check_count;
    int         error_count;
    bit         accepted;
    bit         timed_out;

    tb_clock clock_i (
        .clk_o      (clk),
        .m_reset_no (m_reset_n)
    );

    decim_stream_top dut_i (
        .clk_i        (clk),
        .m_reset_ni   (m_reset_n),
        .in_sample_i  (in_sample),
        .in_valid_i   (in_valid),
        .in_full_o    (in_full),
        .out_result_o (out_result),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready),
        .drop_count_o (drop_count)
    );

    task automatic check(input bit ok, input string msg);
        check_count++;
        assert (ok) else begin
            $display("[ERROR] %0t: %s", $time, msg);
            error_count++;
        end
    endtask

    function automatic sample_t make_sample(input int data, input bit user, input bit last);
        sample_t s;
        s.data = SAMPLE_WIDTH'(data);
        s.user = user;
        s.last = last;
        return s;
    endfunction

    // One cycle driven at the falling edge. A transfer seen here completes at the next
    // rising edge, and a sample counts as written only if in_full was low as it was driven
    task automatic drive_cycle(input bit valid, input sample_t s, input bit ready);
        result_t exp;
        @(negedge clk);
        if (out_valid && ready) begin
            last_result = out_result;
            result_count++;
            if (exp_q.size() == 0) begin
                check(1'b0, "a result appeared that the model did not expect");
            end else begin
                exp = exp_q.pop_front();
                check(out_result == exp,
                      $sformatf("got sum %0d user %b last %b, expected sum %0d user %b last %b",
                                out_result.sum, out_result.user, out_result.last,
                                exp.sum, exp.user, exp.last));
            end
        end
        accepted = valid && !in_full;
        drop_expected += int'(valid && in_full);
        in_valid  = valid;
        in_sample = s;
        out_ready = ready;
        // The reference model closes a window after DECIM samples or on a frame end
        if (accepted) begin
            model_sum += int'(s.data);
            model_cnt++;
            if (model_cnt == DECIM || s.last) begin
                exp.sum  = SUM_WIDTH'(model_sum);
                exp.user = s.user;
                exp.last = s.last;
                exp_q.push_back(exp);
                model_sum = 0;
                model_cnt = 0;
            end
        end
    endtask

    task automatic drain_results(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            drive_cycle(1'b0, '0, 1'b1);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in %s: %0d expected results never appeared", name, exp_q.size());
            timed_out = 1'b1;
        end
        // A few idle cycles catch any result the model does not know about
        repeat (4) drive_cycle(1'b0, '0, 1'b1);
    endtask

    // The closing sample is offered again until the input FIFO has room for it
    task automatic flush_window(input string name);
        int tries;
        tries    = 0;
        accepted = 1'b0;
        while (!accepted && tries < DRAIN_TIMEOUT) begin
            drive_cycle(1'b1, make_sample(3, 1'b1, 1'b1), 1'b1);
            tries++;
        end
        if (!accepted) begin
            $display("Timeout in %s: the closing sample was never written", name);
            timed_out = 1'b1;
        end
        drain_results(name);
    endtask

    task automatic idle_after_reset();
        drive_cycle(1'b0, '0, 1'b0);
        check(!out_valid && !in_full && drop_count == '0, "outputs are not idle after reset");
    endtask

    task automatic full_window_sum();
        sample_t s [4];
        int first;
        s[0] = make_sample(1200, 1'b0, 1'b0);
        s[1] = make_sample(-3100, 1'b1, 1'b0);
        s[2] = make_sample(455, 1'b0, 1'b0);
        s[3] = make_sample(-17, 1'b1, 1'b0);
        first = result_count;
        foreach (s[i]) drive_cycle(1'b1, s[i], 1'b1);
        drain_results("full window");
        check(result_count == first + 1, "a full window did not give exactly one result");
        check(int'(last_result.sum) == -1462 && last_result.user && !last_result.last,
              "full window result has a wrong sum, tag or last flag");
    endtask

    task automatic early_frame_end();
        int first;
        int i;
        first = result_count;
        drive_cycle(1'b1, make_sample(500, 1'b0, 1'b0), 1'b1);
        drive_cycle(1'b1, make_sample(-900, 1'b1, 1'b1), 1'b1);
        drain_results("early frame end");
        check(result_count == first + 1 && int'(last_result.sum) == -400 && last_result.last,
              "early frame end result is wrong");
        for (i = 0; i < DECIM; i++) begin
            drive_cycle(1'b1, make_sample(10 * i - 7, 1'b0, 1'b0), 1'b1);
        end
        drain_results("window after frame end");
        check(result_count == first + 2 && int'(last_result.sum) == 32 && !last_result.last,
              "window after the frame end is wrong");
    endtask

    task automatic back_pressure_fill();
        bit saw_full;
        int i;
        saw_full = 1'b0;
        for (i = 0; i < 40; i++) begin
            drive_cycle(1'b1, make_sample($random(seed), 1'b0, 1'b0), 1'b0);
            saw_full |= in_full;
        end
        check(saw_full, "in_full_o never rose under back-pressure");
        drain_results("back-pressure");
        flush_window("back-pressure flush");
    endtask

    task automatic drop_count_match();
        check(drop_expected > 0 && drop_count == CNT_WIDTH'(drop_expected),
              $sformatf("drop count is %0d, expected %0d", drop_count, drop_expected));
    endtask

    task automatic random_stream_order();
        int i;
        for (i = 0; i < 200; i++) begin
            drive_cycle(1'b1, make_sample($random(seed), 1'($random(seed)),
                        ($random(seed) & 7) == 0), ($random(seed) & 3) != 0);
        end
        flush_window("random stream");
        drop_count_match();
    endtask

    initial begin
        int waited;
        int n;
        int errors_before;
        seed      = 32'h19a;
        in_valid  = 1'b0;
        in_sample = '0;
        out_ready = 1'b0;
        waited    = 0;
        while (m_reset_n !== 1'b1 && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (m_reset_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            timed_out = 1'b1;
        end
        for (n = 1; n <= 6 && !timed_out; n++) begin
            errors_before = error_count;
            case (n)
                1: idle_after_reset();
                2: full_window_sum();
                3: early_frame_end();
                4: back_pressure_fill();
                5: drop_count_match();
                6: random_stream_order();
                default: ;
            endcase
            $display("Test %0d finished with %0d errors", n, error_count - errors_before);
        end
        $display("Tests run %0d, checks %0d, errors %0d", n - 1, check_count, error_count);
        if (timed_out || error_count != 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/stream_cfg_pkg.sv
rtl/stream_fmt_pkg.sv
rtl/axis_fifo.sv
rtl/decim_accum.sv
rtl/decim_ctrl.sv
rtl/decim_stream_top.sv
test/tb_clock.sv
test/tb_decim_stream.sv
